// File: sram_bus_port.sv
`timescale 1ns/1ps

module sram_bus_port #(
   parameter type data_t        = sram_dp_pkg::word_t,
   parameter int  WORD_ADR_BITS = 10
) (
   input  logic                   a_clk_i,
   input  logic                   rst_i,

   // bus side, pipelined strobes
   input  logic                   cyc_i,
   input  logic                   stb_i,
   input  logic                   we_i,
   input  logic [WORD_ADR_BITS +
                 $clog2(sram_dp_pkg::LANES /
                        ($bits(data_t) / sram_dp_pkg::LANE_BITS)) - 1:0] adr_i,
   input  data_t                  dat_i,
   output logic                   ack_o,
   output data_t                  dat_o,

   // core side
   output logic [WORD_ADR_BITS-1:0] mem_adr_o,
   output sram_dp_pkg::lane_mask_t  mem_we_o,
   output sram_dp_pkg::word_t       mem_dat_o,
   input  sram_dp_pkg::word_t       mem_dat_i
);

   // ------------------------------------------------------------------------
   // payload geometry, all derived from data_t
   // ------------------------------------------------------------------------
   localparam int PAY_BITS  = $bits(data_t);                      // payload width
   localparam int PAY_LANES = PAY_BITS / sram_dp_pkg::LANE_BITS;  // lanes per payload
   localparam int SLOTS     = sram_dp_pkg::LANES / PAY_LANES;     // payloads per word
   localparam int SEL_BITS  = $clog2(SLOTS);                      // 0 for word, 2 for byte
   localparam int SEL_W     = (SEL_BITS > 0) ? SEL_BITS : 1;      // keep a real vector
   localparam int ADR_BITS  = WORD_ADR_BITS + SEL_BITS;

   // payload lanes, before shifting into place
   localparam sram_dp_pkg::lane_mask_t PAY_MASK =
      sram_dp_pkg::lane_mask_t'((1 << PAY_LANES) - 1);

   logic             req;     // accepted this edge
   logic [SEL_W-1:0] sel;     // slot of current request
   logic [SEL_W-1:0] sel_q;   // slot of request being acked

   assign req = cyc_i & stb_i;

   // low address bits pick the slot, if there are any
   if (SEL_BITS > 0) begin : g_sel
      assign sel = adr_i[SEL_BITS-1:0];
   end else begin : g_nosel
      assign sel = '0;                // word payload, only one slot
   end

   // ------------------------------------------------------------------------
   // request to core
   // ------------------------------------------------------------------------
   assign mem_adr_o = adr_i[ADR_BITS-1:SEL_BITS];  // word address
   assign mem_dat_o = {SLOTS{dat_i}};              // payload in every slot

   // write mask only for a valid write
   always_comb begin
      mem_we_o = '0;
      if (req && we_i) begin
         mem_we_o = PAY_MASK << (sel * PAY_LANES);
      end
   end

   // ------------------------------------------------------------------------
   // ack and read return
   // ------------------------------------------------------------------------
   always_ff @(posedge a_clk_i) begin
      if (rst_i) begin
         ack_o <= 1'b0;
      end else begin
         ack_o <= req;              // fixed one-cycle latency
      end
   end

   // slot follows the request into the ack cycle
   always_ff @(posedge a_clk_i) begin
      if (req) begin
         sel_q <= sel;
      end
   end

   // core word already registered, just pick our slot
   assign dat_o = mem_dat_i[sel_q * PAY_BITS +: PAY_BITS];

endmodule

// File: sram_byte_lane.sv
`timescale 1ns/1ps

module sram_byte_lane #(
   parameter int WORD_ADR_BITS = 10
) (
   input  logic                     a_clk_i,
   input  logic                     rst_i,

   // port a side
   input  logic [WORD_ADR_BITS-1:0] pa_adr_i,
   input  logic                     pa_we_i,
   input  sram_dp_pkg::byte_t       pa_dat_i,
   output sram_dp_pkg::byte_t       pa_dat_o,

   // port b side with collisions already stripped
   input  logic [WORD_ADR_BITS-1:0] pb_adr_i,
   input  logic                     pb_we_i,
   input  sram_dp_pkg::byte_t       pb_dat_i,
   output sram_dp_pkg::byte_t       pb_dat_o
);

   localparam int DEPTH = 1 << WORD_ADR_BITS;

   sram_dp_pkg::byte_t mem [DEPTH];   // lane storage

   // ------------------------------------------------------------------------
   // both ports read-first on one edge
   // ------------------------------------------------------------------------
   always_ff @(posedge a_clk_i) begin
      pa_dat_o <= mem[pa_adr_i];     // old contents
      pb_dat_o <= mem[pb_adr_i];
      if (!rst_i) begin              // nothing lands while in reset
         if (pa_we_i) begin
            mem[pa_adr_i] <= pa_dat_i;
         end
         if (pb_we_i) begin
            mem[pb_adr_i] <= pb_dat_i;  // core drops b where a writes
         end
      end
   end

endmodule

// File: sram_dp_pkg.sv
package sram_dp_pkg;

   // ------------------------------------------------------------------------
   // lane geometry
   // ------------------------------------------------------------------------

   // one byte lane
   localparam int LANE_BITS = 8;

   // byte lanes per word
   localparam int LANES     = 4;

   // full word width, little-endian lane order
   localparam int WORD_BITS = LANES * LANE_BITS;

   // ------------------------------------------------------------------------
   // shared types
   // ------------------------------------------------------------------------

   // memory word, lane n at bits 8n+7:8n
   typedef logic [WORD_BITS-1:0] word_t;

   // single lane value
   typedef logic [LANE_BITS-1:0] byte_t;

   // one write-enable bit per lane
   typedef logic [LANES-1:0]     lane_mask_t;

endpackage

// File: sram_lane_core.sv
`timescale 1ns/1ps

module sram_lane_core #(
   parameter int WORD_ADR_BITS = 10
) (
   input  logic                     a_clk_i,
   input  logic                     rst_i,

   // port a front end
   input  logic [WORD_ADR_BITS-1:0] pa_adr_i,
   input  sram_dp_pkg::lane_mask_t  pa_we_i,
   input  sram_dp_pkg::word_t       pa_dat_i,
   output sram_dp_pkg::word_t       pa_dat_o,

   // port b front end
   input  logic [WORD_ADR_BITS-1:0] pb_adr_i,
   input  sram_dp_pkg::lane_mask_t  pb_we_i,
   input  sram_dp_pkg::word_t       pb_dat_i,
   output sram_dp_pkg::word_t       pb_dat_o
);

   localparam int LB = sram_dp_pkg::LANE_BITS;

   logic                    same_adr;   // both ports on one word
   sram_dp_pkg::lane_mask_t pb_we_ok;   // b enables after arbitration

   // per-lane read bytes, gathered below
   sram_dp_pkg::byte_t      pa_rd [sram_dp_pkg::LANES];
   sram_dp_pkg::byte_t      pb_rd [sram_dp_pkg::LANES];

   // ------------------------------------------------------------------------
   // collision rule, port a has priority per lane
   // ------------------------------------------------------------------------
   assign same_adr = (pa_adr_i == pb_adr_i);

   // b loses only the lanes a writes at the same word
   assign pb_we_ok = same_adr ? (pb_we_i & ~pa_we_i) : pb_we_i;

   // ------------------------------------------------------------------------
   // lane array
   // ------------------------------------------------------------------------
   for (genvar n = 0; n < sram_dp_pkg::LANES; n++) begin : g_lane
      sram_byte_lane #(
         .WORD_ADR_BITS(WORD_ADR_BITS)
      ) u_lane (
         .a_clk_i  (a_clk_i),
         .rst_i    (rst_i),
         .pa_adr_i (pa_adr_i),
         .pa_we_i  (pa_we_i[n]),
         .pa_dat_i (pa_dat_i[n*LB +: LB]),   // lane n slice
         .pa_dat_o (pa_rd[n]),
         .pb_adr_i (pb_adr_i),
         .pb_we_i  (pb_we_ok[n]),
         .pb_dat_i (pb_dat_i[n*LB +: LB]),
         .pb_dat_o (pb_rd[n])
      );
   end

   // reassemble words, lane 0 at the bottom
   always_comb begin
      for (int n = 0; n < sram_dp_pkg::LANES; n++) begin
         pa_dat_o[n*LB +: LB] = pa_rd[n];
         pb_dat_o[n*LB +: LB] = pb_rd[n];
      end
   end

endmodule

// File: tb_wb_sram_dual_port.sv
`timescale 1ns/1ps

module tb_wb_sram_dual_port;

   localparam int AW          = 6;                  // small model array
   localparam int LB          = sram_dp_pkg::LANE_BITS;
   localparam int LANES       = sram_dp_pkg::LANES;
   localparam int BYTES       = LANES << AW;
   localparam int TEST_CYCLES = 300;                // upper bound for all tests
   localparam int MAX_CYCLES  = 2 * TEST_CYCLES;

   logic               a_clk_i;
   logic               rst_i;
   logic               a_cyc_i;
   logic               a_stb_i;
   logic               a_we_i;
   logic [AW-1:0]      a_adr_i;
   sram_dp_pkg::word_t a_dat_i;
   logic               a_ack_o;
   sram_dp_pkg::word_t a_dat_o;
   logic               b_cyc_i;
   logic               b_stb_i;
   logic               b_we_i;
   logic [AW+1:0]      b_adr_i;
   sram_dp_pkg::byte_t b_dat_i;
   logic               b_ack_o;
   sram_dp_pkg::byte_t b_dat_o;

   sram_dp_pkg::byte_t model [BYTES];   // byte address = word*4 + lane
   logic [31:0]        lcg_state = 32'd64;
   int                 errors = 0;
   int                 cycles = 0;

   wb_sram_dual_port #(.WORD_ADR_BITS(AW)) UUT (
      .a_clk_i (a_clk_i), .rst_i   (rst_i),
      .a_cyc_i (a_cyc_i), .a_stb_i (a_stb_i), .a_we_i (a_we_i),
      .a_adr_i (a_adr_i), .a_dat_i (a_dat_i), .a_ack_o (a_ack_o), .a_dat_o (a_dat_o),
      .b_cyc_i (b_cyc_i), .b_stb_i (b_stb_i), .b_we_i (b_we_i),
      .b_adr_i (b_adr_i), .b_dat_i (b_dat_i), .b_ack_o (b_ack_o), .b_dat_o (b_dat_o)
   );

   initial begin
      a_clk_i = 1'b0;
      forever #10 a_clk_i = ~a_clk_i;   // 20 ns period
   end

   // run limit
   always @(posedge a_clk_i) begin
      cycles = cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         $display("timeout: run did not finish within %0d clock cycles", MAX_CYCLES);
         $display("*** TEST FAILED ***");
         $finish;
      end
   end

   // ------------------------------------------------------------------------
   // helpers
   // ------------------------------------------------------------------------
   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic sram_dp_pkg::word_t model_word(input logic [AW-1:0] w);
      sram_dp_pkg::word_t v;
      for (int n = 0; n < LANES; n++) begin
         v[n*LB +: LB] = model[int'(w)*LANES + n];   // lane n of word w
      end
      return v;
   endfunction

   task automatic flag_error(input string msg);
      errors++;
      $display("FAIL @%0t: %s", $time, msg);
   endtask

   // drives one bus cycle on both ports and checks acks and data
   task automatic bus_cycle(input logic a_en, input logic a_we, input logic [AW-1:0] a_adr,
                            input sram_dp_pkg::word_t a_dat, input logic b_en,
                            input logic b_we, input logic [AW+1:0] b_adr,
                            input sram_dp_pkg::byte_t b_dat);
      sram_dp_pkg::word_t exp_a;
      sram_dp_pkg::byte_t exp_b;
      logic               live;
      live  = !rst_i;               // requests in reset are dropped
      exp_a = model_word(a_adr);    // read-first returns old contents
      exp_b = model[int'(b_adr)];
      a_cyc_i = a_en;
      a_stb_i = a_en;
      a_we_i  = a_we;
      a_adr_i = a_adr;
      a_dat_i = a_dat;
      b_cyc_i = b_en;
      b_stb_i = b_en;
      b_we_i  = b_we;
      b_adr_i = b_adr;
      b_dat_i = b_dat;
      if (live && b_en && b_we) model[int'(b_adr)] = b_dat;
      if (live && a_en && a_we) begin
         for (int n = 0; n < LANES; n++)
            model[int'(a_adr)*LANES + n] = a_dat[n*LB +: LB];   // a last so a wins
      end
      @(posedge a_clk_i);
      #1;                           // outputs settled after the edge
      if (a_ack_o !== (live && a_en)) flag_error($sformatf("port a ack is %b", a_ack_o));
      if (b_ack_o !== (live && b_en)) flag_error($sformatf("port b ack is %b", b_ack_o));
      if (live && a_en && a_dat_o !== exp_a)
         flag_error($sformatf("port a data %h, expected %h", a_dat_o, exp_a));
      if (live && b_en && b_dat_o !== exp_b)
         flag_error($sformatf("port b data %h, expected %h", b_dat_o, exp_b));
   endtask

   task automatic idle_cycle();
      bus_cycle(1'b0, 1'b0, '0, '0, 1'b0, 1'b0, '0, '0);
   endtask

   // ------------------------------------------------------------------------
   // directed tests
   // ------------------------------------------------------------------------
   task automatic fill_memory();
      for (int w = 0; w < (1 << AW); w++) bus_cycle(1'b1, 1'b1, AW'(w), lcg_next(),
                                                    1'b0, 1'b0, '0, '0);
      idle_cycle();
   endtask

   task automatic reset_blocks_writes();
      logic [AW-1:0] w;
      w     = AW'(5);
      rst_i = 1'b1;
      repeat (4) bus_cycle(1'b1, 1'b1, w, 32'hdead_beef, 1'b1, 1'b1, {w, 2'd1}, 8'h5a);
      rst_i = 1'b0;
      idle_cycle();                                  // acks still low here
      bus_cycle(1'b1, 1'b0, w, '0, 1'b1, 1'b0, {w, 2'd1}, '0);   // old data expected
      idle_cycle();
   endtask

   task automatic word_to_bytes();
      logic [31:0]   r;
      logic [AW-1:0] w;
      r = lcg_next();
      w = r[AW-1:0];
      r = lcg_next();
      bus_cycle(1'b1, 1'b1, w, r, 1'b0, 1'b0, '0, '0);
      for (int n = 0; n < LANES; n++) begin
         bus_cycle(1'b0, 1'b0, '0, '0, 1'b1, 1'b0, {w, 2'(n)}, '0);
         if (b_dat_o !== r[n*LB +: LB])
            flag_error($sformatf("lane %0d byte %h, word was %h", n, b_dat_o, r));
      end
      idle_cycle();
   endtask

   task automatic bytes_to_word();
      logic [31:0]        r;
      logic [AW-1:0]      w;
      sram_dp_pkg::word_t v;
      r = lcg_next();
      w = r[AW-1:0];
      for (int n = 0; n < LANES; n++) begin
         r = lcg_next();
         v[n*LB +: LB] = r[7:0];
         bus_cycle(1'b0, 1'b0, '0, '0, 1'b1, 1'b1, {w, 2'(n)}, r[7:0]);
      end
      bus_cycle(1'b1, 1'b0, w, '0, 1'b0, 1'b0, '0, '0);
      if (a_dat_o !== v) flag_error($sformatf("assembled word %h, expected %h", a_dat_o, v));
      idle_cycle();
   endtask

   // random mix with b always on a different word than a
   task automatic pipelined_traffic();
      logic [31:0]   r;
      logic [AW-1:0] wa;
      logic [AW-1:0] wb;
      for (int i = 0; i < 100; i++) begin
         r  = lcg_next();
         wa = r[6 +: AW];
         wb = wa + AW'(1 + (r[16 +: AW] % ((1 << AW) - 1)));
         bus_cycle(r[0] | r[1], r[2], wa, lcg_next(),
                   r[3] | r[4], r[5], {wb, r[29:28]}, r[27:20]);
      end
      idle_cycle();
   endtask

   task automatic write_collision();
      logic [31:0]   d;
      logic [AW-1:0] w;
      d = lcg_next();
      w = d[AW+7:8];
      bus_cycle(1'b1, 1'b1, w, d, 1'b1, 1'b1, {w, 2'd2}, ~d[23:16]);   // same byte
      bus_cycle(1'b1, 1'b0, w, '0, 1'b1, 1'b0, {w, 2'd2}, '0);
      if (a_dat_o !== d) flag_error($sformatf("collided word %h, expected %h", a_dat_o, d));
      if (b_dat_o !== d[23:16]) flag_error($sformatf("collided byte %h", b_dat_o));
      idle_cycle();
   endtask

   task automatic read_during_write();
      logic [31:0]        d;
      logic [AW-1:0]      w;
      sram_dp_pkg::word_t old_w;
      d     = lcg_next();
      w     = d[AW+3:4];
      old_w = model_word(w);
      bus_cycle(1'b1, 1'b0, w, '0, 1'b1, 1'b1, {w, 2'd1}, d[7:0]);
      if (a_dat_o !== old_w) flag_error($sformatf("a read %h during b write", a_dat_o));
      bus_cycle(1'b1, 1'b0, w, '0, 1'b0, 1'b0, '0, '0);
      if (a_dat_o[15:8] !== d[7:0]) flag_error($sformatf("a reread %h", a_dat_o));
      bus_cycle(1'b1, 1'b1, w, d, 1'b1, 1'b0, {w, 2'd3}, '0);   // b sees old byte
      bus_cycle(1'b0, 1'b0, '0, '0, 1'b1, 1'b0, {w, 2'd3}, '0);
      if (b_dat_o !== d[31:24]) flag_error($sformatf("b reread %h", b_dat_o));
      idle_cycle();
   endtask

   // ------------------------------------------------------------------------
   // sequence
   // ------------------------------------------------------------------------
   initial begin
      rst_i   = 1'b1;
      a_cyc_i = 1'b0;
      a_stb_i = 1'b0;
      a_we_i  = 1'b0;
      a_adr_i = '0;
      a_dat_i = '0;
      b_cyc_i = 1'b0;
      b_stb_i = 1'b0;
      b_we_i  = 1'b0;
      b_adr_i = '0;
      b_dat_i = '0;
      repeat (4) idle_cycle();
      rst_i = 1'b0;
      fill_memory();                // known contents for the model
      reset_blocks_writes();
      word_to_bytes();
      bytes_to_word();
      pipelined_traffic();
      write_collision();
      read_during_write();
      $display("clock cycles: %0d  errors: %0d", cycles, errors);
      if (errors == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

// File: wb_sram_dual_port.f
sram_dp_pkg.sv
sram_bus_port.sv
sram_byte_lane.sv
sram_lane_core.sv
wb_sram_dual_port.sv
wb_sram_dual_port_sva.sv
tb_wb_sram_dual_port.sv

// File: wb_sram_dual_port.sv
`timescale 1ns/1ps

module wb_sram_dual_port #(
   parameter int WORD_ADR_BITS = 10
) (
   input  logic                     a_clk_i,
   input  logic                     rst_i,

   // port a, 32-bit word bus
   input  logic                     a_cyc_i,
   input  logic                     a_stb_i,
   input  logic                     a_we_i,
   input  logic [WORD_ADR_BITS-1:0] a_adr_i,
   input  sram_dp_pkg::word_t       a_dat_i,
   output logic                     a_ack_o,
   output sram_dp_pkg::word_t       a_dat_o,

   // port b, 8-bit byte bus, low two address bits pick the lane
   input  logic                     b_cyc_i,
   input  logic                     b_stb_i,
   input  logic                     b_we_i,
   input  logic [WORD_ADR_BITS+1:0] b_adr_i,
   input  sram_dp_pkg::byte_t       b_dat_i,
   output logic                     b_ack_o,
   output sram_dp_pkg::byte_t       b_dat_o
);

   // ------------------------------------------------------------------------
   // front end to core wiring
   // ------------------------------------------------------------------------
   logic [WORD_ADR_BITS-1:0] pa_adr;
   sram_dp_pkg::lane_mask_t  pa_we;
   sram_dp_pkg::word_t       pa_wdat;
   sram_dp_pkg::word_t       pa_rdat;

   logic [WORD_ADR_BITS-1:0] pb_adr;
   sram_dp_pkg::lane_mask_t  pb_we;
   sram_dp_pkg::word_t       pb_wdat;   // byte copied into all lanes
   sram_dp_pkg::word_t       pb_rdat;

   sram_bus_port #(
      .data_t        (sram_dp_pkg::word_t),
      .WORD_ADR_BITS (WORD_ADR_BITS)
   ) u_port_a (
      .a_clk_i   (a_clk_i),
      .rst_i     (rst_i),
      .cyc_i     (a_cyc_i),
      .stb_i     (a_stb_i),
      .we_i      (a_we_i),
      .adr_i     (a_adr_i),
      .dat_i     (a_dat_i),
      .ack_o     (a_ack_o),
      .dat_o     (a_dat_o),
      .mem_adr_o (pa_adr),
      .mem_we_o  (pa_we),
      .mem_dat_o (pa_wdat),
      .mem_dat_i (pa_rdat)
   );

   sram_bus_port #(
      .data_t        (sram_dp_pkg::byte_t),
      .WORD_ADR_BITS (WORD_ADR_BITS)
   ) u_port_b (
      .a_clk_i   (a_clk_i),
      .rst_i     (rst_i),
      .cyc_i     (b_cyc_i),
      .stb_i     (b_stb_i),
      .we_i      (b_we_i),
      .adr_i     (b_adr_i),
      .dat_i     (b_dat_i),
      .ack_o     (b_ack_o),
      .dat_o     (b_dat_o),
      .mem_adr_o (pb_adr),
      .mem_we_o  (pb_we),
      .mem_dat_o (pb_wdat),
      .mem_dat_i (pb_rdat)
   );

   // shared storage, a wins on lane collisions
   sram_lane_core #(
      .WORD_ADR_BITS (WORD_ADR_BITS)
   ) u_core (
      .a_clk_i  (a_clk_i),
      .rst_i    (rst_i),
      .pa_adr_i (pa_adr),
      .pa_we_i  (pa_we),
      .pa_dat_i (pa_wdat),
      .pa_dat_o (pa_rdat),
      .pb_adr_i (pb_adr),
      .pb_we_i  (pb_we),
      .pb_dat_i (pb_wdat),
      .pb_dat_o (pb_rdat)
   );

endmodule

// File: wb_sram_dual_port_sva.sv
`timescale 1ns/1ps

module wb_sram_dual_port_sva (
   input logic a_clk_i,
   input logic rst_i,
   input logic a_cyc_i,
   input logic a_stb_i,
   input logic a_ack_i,
   input logic b_cyc_i,
   input logic b_stb_i,
   input logic b_ack_i
);

   // ------------------------------------------------------------------------
   // ack follows an accepted request by exactly one edge
   // ------------------------------------------------------------------------
   a_req_ack : assert property (@(posedge a_clk_i) !rst_i && a_cyc_i && a_stb_i |=> a_ack_i)
      else $error("port a request not acked on the next cycle");
   b_req_ack : assert property (@(posedge a_clk_i) !rst_i && b_cyc_i && b_stb_i |=> b_ack_i)
      else $error("port b request not acked on the next cycle");

   // no stray acks
   a_ack_src : assert property (@(posedge a_clk_i)
      a_ack_i |-> $past(!rst_i && a_cyc_i && a_stb_i))
      else $error("port a ack without an accepted request");
   b_ack_src : assert property (@(posedge a_clk_i)
      b_ack_i |-> $past(!rst_i && b_cyc_i && b_stb_i))
      else $error("port b ack without an accepted request");

   ack_after_rst : assert property (@(posedge a_clk_i) $past(rst_i) |-> !a_ack_i && !b_ack_i)
      else $error("ack high in the cycle after reset");   // both ports

endmodule

bind wb_sram_dual_port wb_sram_dual_port_sva u_sva (
   .a_clk_i (a_clk_i), .rst_i   (rst_i),
   .a_cyc_i (a_cyc_i), .a_stb_i (a_stb_i), .a_ack_i (a_ack_o),
   .b_cyc_i (b_cyc_i), .b_stb_i (b_stb_i), .b_ack_i (b_ack_o)
);
